/* source/dct_types_pkg.sv */
package dct_types_pkg;

    // ########################################
    // Block geometry.
    // ########################################
    localparam int N_PT  = 8;   // Points per row, rows per block.
    localparam int CNT_W = 3;   // Row and column index width.

    // ########################################
    // Sample widths.
    // ########################################
    localparam int PIX_W  = 9;  // Signed input samples.
    localparam int ROW_W  = 13; // After the row pass, also the buffer width.
    localparam int COL_W  = 15; // Final coefficients.
    localparam int COEF_W = 12; // Signed table entries.

    // Rounding shifts of the two passes.
    localparam int ROW_SHIFT = 8;
    localparam int COL_SHIFT = 10;

    // Transpose RAM, two 16-bit lanes per word.
    localparam int RAM_AW = 6;
    localparam int RAM_DW = 32;

    // ########################################
    // DCT basis, scaled by 1024.
    // ########################################
    // Row k holds basis k over sample index n.
    localparam logic signed [COEF_W-1:0] DCT_COEF [N_PT][N_PT] = '{
        '{ 362,  362,  362,  362,  362,  362,  362,  362},
        '{ 502,  426,  284,  100, -100, -284, -426, -502},
        '{ 473,  196, -196, -473, -473, -196,  196,  473},
        '{ 426, -100, -502, -284,  284,  502,  100, -426},
        '{ 362, -362, -362,  362,  362, -362, -362,  362},
        '{ 284, -502,  100,  426, -426, -100,  502, -284},
        '{ 196, -473,  473, -196, -196,  473, -473,  196},
        '{ 100, -284,  426, -502,  502, -426,  284, -100}
    };

endpackage

/* source/dct_ctrl_pkg.sv */
package dct_ctrl_pkg;

    // ########################################
    // 1D transform sequencer.
    // ########################################

    // IDLE waits for a row.
    // ACCUM runs one sample per cycle through the MACs.
    // HOLD presents the result until it is taken.
    typedef enum logic [1:0] {
        IDLE,
        ACCUM,
        HOLD
    } mac_state_e;

endpackage

/* source/dp_ram_be.sv */
module dp_ram_be #(
    parameter int DW    = 32,
    parameter int DEPTH = 64
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] wa_i,
    input  logic [DW-1:0]            wd_i,
    input  logic [DW/8-1:0]          wbe_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] ra_i,
    input  logic                     re_i,
    output logic [DW-1:0]            rd_o
);

    logic [DW-1:0] mem [DEPTH];

    // Byte-lane write.
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int b = 0; b < DW / 8; b++) begin
                if (wbe_i[b]) begin
                    mem[wa_i][8*b +: 8] <= wd_i[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (re_i) begin
            rd_o <= mem[ra_i]; // Registered read.
        end
    end

endmodule

/* source/dct_1d.sv */
module dct_1d #(
    parameter int IN_W  = dct_types_pkg::PIX_W,
    parameter int OUT_W = dct_types_pkg::ROW_W,
    parameter int SHIFT = dct_types_pkg::ROW_SHIFT
) (
    input  logic                              clk,
    input  logic                              resetn,

    input  logic signed [IN_W-1:0]            d_i [dct_types_pkg::N_PT],
    input  logic [dct_types_pkg::CNT_W-1:0]   d_cnt_i,
    input  logic                              d_valid_i,
    output logic                              d_hold_o,

    output logic signed [OUT_W-1:0]           q_o [dct_types_pkg::N_PT],
    output logic [dct_types_pkg::CNT_W-1:0]   q_cnt_o,
    output logic                              q_valid_o,
    input  logic                              q_hold_i
);

    // Eight products of IN_W x COEF_W bits.
    localparam int ACC_W = IN_W + dct_types_pkg::COEF_W + dct_types_pkg::CNT_W;

    dct_ctrl_pkg::mac_state_e               state;
    logic [dct_types_pkg::CNT_W-1:0]        idx;
    logic signed [IN_W-1:0]                 d_r [dct_types_pkg::N_PT];
    logic signed [ACC_W-1:0]                acc [dct_types_pkg::N_PT];
    logic signed [ACC_W-1:0]                rnd [dct_types_pkg::N_PT];
    logic                                   in_xfer;
    logic                                   out_xfer;
    logic [dct_types_pkg::N_PT*OUT_W-1:0]   q_flat;

    assign in_xfer  = d_valid_i & ~d_hold_o;
    assign out_xfer = q_valid_o & ~q_hold_i;

    // ########################################
    // Sequencer.
    // ########################################
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= dct_ctrl_pkg::IDLE;
            idx      <= '0;
            d_hold_o <= 1'b0;
        end else begin
            case (state)
                dct_ctrl_pkg::IDLE: begin
                    if (in_xfer) begin
                        state    <= dct_ctrl_pkg::ACCUM;
                        d_hold_o <= 1'b1; // One row in flight.
                    end
                end
                dct_ctrl_pkg::ACCUM: begin
                    idx <= idx + 1'b1; // Wraps back to zero.
                    if (&idx) begin
                        state <= dct_ctrl_pkg::HOLD;
                    end
                end
                dct_ctrl_pkg::HOLD: begin
                    if (out_xfer) begin
                        state    <= dct_ctrl_pkg::IDLE;
                        d_hold_o <= 1'b0;
                    end
                end
                default: begin
                    state <= dct_ctrl_pkg::IDLE;
                end
            endcase
        end
    end

    // ########################################
    // MAC datapath.
    // ########################################
    always_ff @(posedge clk) begin
        if (in_xfer) begin
            d_r     <= d_i;
            q_cnt_o <= d_cnt_i;
            for (int k = 0; k < dct_types_pkg::N_PT; k++) begin
                acc[k] <= '0;
            end
        end else if (state == dct_ctrl_pkg::ACCUM) begin
            // Sample idx times column idx of the basis.
            for (int k = 0; k < dct_types_pkg::N_PT; k++) begin
                acc[k] <= acc[k] + d_r[idx] * dct_types_pkg::DCT_COEF[k][idx];
            end
        end
    end

    // Round half up, then clip to OUT_W.
    always_comb begin
        for (int k = 0; k < dct_types_pkg::N_PT; k++) begin
            rnd[k] = (acc[k] + (ACC_W'(1) <<< (SHIFT - 1))) >>> SHIFT;
            if (rnd[k][ACC_W-1:OUT_W-1] == '0 || rnd[k][ACC_W-1:OUT_W-1] == '1) begin
                q_o[k] = rnd[k][OUT_W-1:0];
            end else if (rnd[k][ACC_W-1]) begin
                q_o[k] = {1'b1, {(OUT_W - 1){1'b0}}};
            end else begin
                q_o[k] = {1'b0, {(OUT_W - 1){1'b1}}};
            end
        end
    end

    assign q_valid_o = (state == dct_ctrl_pkg::HOLD);

    always_comb begin
        for (int k = 0; k < dct_types_pkg::N_PT; k++) begin
            q_flat[k*OUT_W +: OUT_W] = q_o[k];
        end
    end

    // Output row is frozen while it waits.
    a_q_stable: assert property (@(posedge clk) disable iff (!resetn)
        q_valid_o && q_hold_i |=> q_valid_o && $stable(q_flat) && $stable(q_cnt_o));

    // No new row may land during accumulation.
    a_hold_accum: assert property (@(posedge clk) disable iff (!resetn)
        state == dct_ctrl_pkg::ACCUM |-> d_hold_o);

endmodule

/* source/transpose.sv */
module transpose #(
    parameter int QW = dct_types_pkg::ROW_W
) (
    input  logic                              clk,
    input  logic                              resetn,

    input  logic signed [QW-1:0]              d_i [dct_types_pkg::N_PT],
    input  logic [dct_types_pkg::CNT_W-1:0]   d_cnt_i,
    input  logic                              d_valid_i,
    output logic                              d_hold_o,

    output logic signed [QW-1:0]              q_o [dct_types_pkg::N_PT],
    output logic [dct_types_pkg::CNT_W-1:0]   q_cnt_o,
    output logic                              q_valid_o,
    input  logic                              q_hold_i
);

    logic                                   full;
    logic                                   empty;
    logic [1:0]                             wptr;
    logic [1:0]                             rptr;
    logic [dct_types_pkg::CNT_W-1:0]        wr_cnt;  // Sample being written.
    logic [dct_types_pkg::CNT_W-1:0]        rd_col;  // Column being read.
    logic [1:0]                             rd_cnt;  // Row pair being read.
    logic                                   rd_go;

    logic [dct_types_pkg::RAM_AW-1:0]       wa;
    logic [dct_types_pkg::RAM_AW-1:0]       ra;
    logic [dct_types_pkg::RAM_DW-1:0]       wd;
    logic [dct_types_pkg::RAM_DW-1:0]       rd;
    logic [dct_types_pkg::RAM_DW/8-1:0]     wbe;
    logic                                   we;
    logic                                   re;
    logic signed [dct_types_pkg::RAM_DW/2-1:0] wsamp;

    logic                                   re_q;
    logic [1:0]                             rd_cnt_q;
    logic signed [QW-1:0]                   qq [6];

    // ########################################
    // Bank pointers.
    // ########################################
    assign full     = (wptr[1] != rptr[1]) && (wptr[0] == rptr[0]);
    assign empty    = (wptr == rptr);
    assign d_hold_o = full | ~&wr_cnt;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wptr   <= '0;
            wr_cnt <= '0;
        end else if (d_valid_i && !full) begin
            wr_cnt <= wr_cnt + 1'b1;
            if (&wr_cnt && &d_cnt_i) begin
                wptr <= wptr + 1'b1; // Block complete.
            end
        end
    end

    // Word address is bank, column, row pair; lane is the row LSB.
    assign wsamp = d_i[wr_cnt];
    assign wd    = {2{wsamp}};
    assign wa    = {wptr[0], wr_cnt, d_cnt_i[dct_types_pkg::CNT_W-1:1]};
    assign wbe   = {{(dct_types_pkg::RAM_DW/16){d_cnt_i[0]}},
                    {(dct_types_pkg::RAM_DW/16){~d_cnt_i[0]}}};
    assign we    = d_valid_i & ~full;

    // ########################################
    // Read side.
    // ########################################
    // Stall on the last read, or while a finished row waits.
    assign rd_go = !empty && !(q_hold_i && (&rd_cnt || q_valid_o));
    assign re    = rd_go;
    assign ra    = {rptr[0], rd_col, rd_cnt};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rptr   <= '0;
            rd_cnt <= '0;
            rd_col <= '0;
        end else if (rd_go) begin
            rd_cnt <= rd_cnt + 1'b1;
            if (&rd_cnt) begin
                rd_col <= rd_col + 1'b1;
                if (&rd_col) begin
                    rptr <= rptr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            q_valid_o <= 1'b0;
            q_cnt_o   <= '0;
        end else if (rd_go && &rd_cnt) begin
            q_valid_o <= 1'b1;
            q_cnt_o   <= rd_col;
        end else if (!q_hold_i) begin
            q_valid_o <= 1'b0;
        end
    end

    dp_ram_be #(
        .DW    (dct_types_pkg::RAM_DW),
        .DEPTH (1 << dct_types_pkg::RAM_AW)
    ) mem (
        .clk   (clk),
        .wa_i  (wa),
        .wd_i  (wd),
        .wbe_i (wbe),
        .we_i  (we),
        .ra_i  (ra),
        .re_i  (re),
        .rd_o  (rd)
    );

    always_ff @(posedge clk) begin
        if (!resetn) begin
            re_q <= 1'b0;
        end else begin
            re_q <= re;
        end
    end

    always_ff @(posedge clk) begin
        if (re) begin
            rd_cnt_q <= rd_cnt;
        end
    end

    // First three pairs are kept; the last pair stays on the RAM output.
    always_ff @(posedge clk) begin
        if (re_q && !(&rd_cnt_q)) begin
            qq[2*rd_cnt_q]   <= rd[QW-1:0];
            qq[2*rd_cnt_q+1] <= rd[dct_types_pkg::RAM_DW/2 +: QW];
        end
    end

    always_comb begin
        for (int i = 0; i < 6; i++) begin
            q_o[i] = qq[i];
        end
        q_o[6] = rd[QW-1:0];
        q_o[7] = rd[dct_types_pkg::RAM_DW/2 +: QW];
    end

    // No RAM write into the bank under read.
    a_no_wr_full: assert property (@(posedge clk) disable iff (!resetn)
        we |-> empty || (wa[dct_types_pkg::RAM_AW-1] != rptr[0]));

    property p_cnt_step;
        logic [dct_types_pkg::CNT_W-1:0] c;
        (q_valid_o && !q_hold_i, c = q_cnt_o) ##1 q_valid_o[->1] |-> q_cnt_o == c + 1'b1;
    endproperty

    a_cnt_step: assert property (@(posedge clk) disable iff (!resetn) p_cnt_step);

endmodule

/* source/dct_2d.sv */
module dct_2d (
    input  logic                                     clk,
    input  logic                                     resetn,

    input  logic signed [dct_types_pkg::PIX_W-1:0]   pix_i [dct_types_pkg::N_PT],
    input  logic [dct_types_pkg::CNT_W-1:0]          pix_row_i,
    input  logic                                     pix_valid_i,
    output logic                                     pix_hold_o,

    output logic signed [dct_types_pkg::COL_W-1:0]   coef_o [dct_types_pkg::N_PT],
    output logic [dct_types_pkg::CNT_W-1:0]          coef_col_o,
    output logic                                     coef_valid_o,
    input  logic                                     coef_hold_i
);

    // Row pass to transpose.
    logic signed [dct_types_pkg::ROW_W-1:0]  row_q [dct_types_pkg::N_PT];
    logic [dct_types_pkg::CNT_W-1:0]         row_cnt;
    logic                                    row_valid;
    logic                                    row_hold;

    // Transpose to column pass.
    logic signed [dct_types_pkg::ROW_W-1:0]  tr_q [dct_types_pkg::N_PT];
    logic [dct_types_pkg::CNT_W-1:0]         tr_cnt;
    logic                                    tr_valid;
    logic                                    tr_hold;

    dct_1d #(
        .IN_W  (dct_types_pkg::PIX_W),
        .OUT_W (dct_types_pkg::ROW_W),
        .SHIFT (dct_types_pkg::ROW_SHIFT)
    ) u_row (
        .clk       (clk),
        .resetn    (resetn),
        .d_i       (pix_i),
        .d_cnt_i   (pix_row_i),
        .d_valid_i (pix_valid_i),
        .d_hold_o  (pix_hold_o),
        .q_o       (row_q),
        .q_cnt_o   (row_cnt),
        .q_valid_o (row_valid),
        .q_hold_i  (row_hold)
    );

    transpose #(
        .QW (dct_types_pkg::ROW_W)
    ) u_tr (
        .clk       (clk),
        .resetn    (resetn),
        .d_i       (row_q),
        .d_cnt_i   (row_cnt),
        .d_valid_i (row_valid),
        .d_hold_o  (row_hold),
        .q_o       (tr_q),
        .q_cnt_o   (tr_cnt),
        .q_valid_o (tr_valid),
        .q_hold_i  (tr_hold)
    );

    dct_1d #(
        .IN_W  (dct_types_pkg::ROW_W),
        .OUT_W (dct_types_pkg::COL_W),
        .SHIFT (dct_types_pkg::COL_SHIFT)
    ) u_col (
        .clk       (clk),
        .resetn    (resetn),
        .d_i       (tr_q),
        .d_cnt_i   (tr_cnt),
        .d_valid_i (tr_valid),
        .d_hold_o  (tr_hold),
        .q_o       (coef_o),
        .q_cnt_o   (coef_col_o),
        .q_valid_o (coef_valid_o),
        .q_hold_i  (coef_hold_i)
    );

endmodule

/* sim/dct_2d_model.svh */
`ifndef DCT_2D_MODEL_SVH
`define DCT_2D_MODEL_SVH

// Round half up by 2**shift, then clip to a signed width.
function automatic int round_shift_sat(input longint acc, input int shift, input int width);
    longint r;
    longint lim;
    r   = (acc + (longint'(1) <<< (shift - 1))) >>> shift;
    lim = longint'(1) <<< (width - 1);
    if (r > lim - 1) begin
        r = lim - 1;
    end else if (r < -lim) begin
        r = -lim;
    end
    return int'(r);
endfunction

// One 8-point pass, y[k] is the sum over n of x[n] * C[k][n].
function automatic void dct_8pt(input int x [dct_types_pkg::N_PT], input int shift,
                                input int width, output int y [dct_types_pkg::N_PT]);
    longint acc;
    for (int k = 0; k < dct_types_pkg::N_PT; k++) begin
        acc = 0;
        for (int n = 0; n < dct_types_pkg::N_PT; n++) begin
            acc += longint'(x[n]) * longint'(dct_types_pkg::DCT_COEF[k][n]);
        end
        y[k] = round_shift_sat(acc, shift, width);
    end
endfunction

// Rows first, then columns. coef[c][u] holds Y[u][c].
function automatic void transform_block(input int pix [dct_types_pkg::N_PT][dct_types_pkg::N_PT],
                                        output int coef [dct_types_pkg::N_PT][dct_types_pkg::N_PT]);
    int row_res [dct_types_pkg::N_PT][dct_types_pkg::N_PT];
    int vec [dct_types_pkg::N_PT];
    int res [dct_types_pkg::N_PT];
    for (int r = 0; r < dct_types_pkg::N_PT; r++) begin
        for (int n = 0; n < dct_types_pkg::N_PT; n++) begin
            vec[n] = pix[r][n];
        end
        dct_8pt(vec, dct_types_pkg::ROW_SHIFT, dct_types_pkg::ROW_W, res);
        for (int k = 0; k < dct_types_pkg::N_PT; k++) begin
            row_res[r][k] = res[k];
        end
    end
    for (int c = 0; c < dct_types_pkg::N_PT; c++) begin
        for (int r = 0; r < dct_types_pkg::N_PT; r++) begin
            vec[r] = row_res[r][c]; // Walk down one column.
        end
        dct_8pt(vec, dct_types_pkg::COL_SHIFT, dct_types_pkg::COL_W, res);
        for (int u = 0; u < dct_types_pkg::N_PT; u++) begin
            coef[c][u] = res[u];
        end
    end
endfunction

`endif

/* sim/tb_dct_2d.sv */
module tb_dct_2d;

    `include "dct_2d_model.svh"

    localparam int NP      = dct_types_pkg::N_PT;
    localparam int IN_BITS = dct_types_pkg::CNT_W + NP * dct_types_pkg::PIX_W;
    localparam int OUT_BITS = NP * dct_types_pkg::COL_W;
    localparam int N_RAND  = 12;  // Random blocks.
    localparam int N_STALL = 4;   // Blocks sent against a held output.
    localparam int N_BLK   = 4 + N_RAND + N_STALL;
    localparam int LIMIT   = 40 * NP * N_BLK + 6 * NP * NP + 1000;
    localparam int PIX_MAX = (1 << (dct_types_pkg::PIX_W - 1)) - 1;

    logic                                   clk;
    logic                                   resetn;
    logic signed [dct_types_pkg::PIX_W-1:0] pix_i [NP];
    logic [dct_types_pkg::CNT_W-1:0]        pix_row_i;
    logic                                   pix_valid_i;
    logic                                   pix_hold_o;
    logic signed [dct_types_pkg::COL_W-1:0] coef_o [NP];
    logic [dct_types_pkg::CNT_W-1:0]        coef_col_o;
    logic                                   coef_valid_o;
    logic                                   coef_hold_i;
    logic [OUT_BITS-1:0]                    coef_flat;

    logic [IN_BITS-1:0]  send_q [$];  // {row index, samples}.
    logic [OUT_BITS-1:0] exp_q [$];
    string               name_q [$];
    logic [OUT_BITS-1:0] exp_row;
    string               exp_name;
    logic                taken;
    int                  rows_in;
    int                  rows_out;
    int                  cycles;
    int                  gap_pct;
    int                  hold_pct;

    dct_2d u_dut (
        .clk          (clk),
        .resetn       (resetn),
        .pix_i        (pix_i),
        .pix_row_i    (pix_row_i),
        .pix_valid_i  (pix_valid_i),
        .pix_hold_o   (pix_hold_o),
        .coef_o       (coef_o),
        .coef_col_o   (coef_col_o),
        .coef_valid_o (coef_valid_o),
        .coef_hold_i  (coef_hold_i)
    );

    always_comb begin
        for (int k = 0; k < NP; k++) begin
            coef_flat[k*dct_types_pkg::COL_W +: dct_types_pkg::COL_W] = coef_o[k];
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    // Kinds 0 to 3 are the corner blocks, anything else is random.
    function automatic void make_block(input int kind, output int blk [NP][NP]);
        for (int r = 0; r < NP; r++) begin
            for (int c = 0; c < NP; c++) begin
                case (kind)
                    0: blk[r][c] = 0;
                    1: blk[r][c] = PIX_MAX;
                    2: blk[r][c] = -PIX_MAX - 1;
                    3: blk[r][c] = ((r + c) % 2 == 0) ? PIX_MAX : -PIX_MAX - 1;
                    default: blk[r][c] = int'($urandom_range(2 * PIX_MAX + 1)) - PIX_MAX - 1;
                endcase
            end
        end
    endfunction

    function automatic void send_block(input string name, input int blk [NP][NP]);
        int                  coef [NP][NP];
        logic [IN_BITS-1:0]  in_row;
        logic [OUT_BITS-1:0] out_row;
        transform_block(blk, coef);
        for (int r = 0; r < NP; r++) begin
            in_row[NP*dct_types_pkg::PIX_W +: dct_types_pkg::CNT_W] = r;
            for (int n = 0; n < NP; n++) begin
                in_row[n*dct_types_pkg::PIX_W +: dct_types_pkg::PIX_W] = blk[r][n];
            end
            send_q.push_back(in_row);
        end
        for (int c = 0; c < NP; c++) begin
            for (int u = 0; u < NP; u++) begin
                out_row[u*dct_types_pkg::COL_W +: dct_types_pkg::COL_W] = coef[c][u];
            end
            exp_q.push_back(out_row);
            name_q.push_back(name);
        end
    endfunction

    task automatic wait_drain();
        while (exp_q.size() > 0) begin
            @(posedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ########################################
    // Input and back-pressure drivers.
    // ########################################
    always @(negedge clk) begin
        if (!pix_valid_i || taken) begin
            taken       = 1'b0;
            pix_valid_i = 1'b0;
            if (send_q.size() > 0 && $urandom_range(99) >= gap_pct) begin
                pix_valid_i = 1'b1;
                pix_row_i   = send_q[0][NP*dct_types_pkg::PIX_W +: dct_types_pkg::CNT_W];
                for (int n = 0; n < NP; n++) begin
                    pix_i[n] = send_q[0][n*dct_types_pkg::PIX_W +: dct_types_pkg::PIX_W];
                end
            end
        end
        coef_hold_i = ($urandom_range(99) < hold_pct);
    end

    // ########################################
    // Scoreboard and timeout.
    // ########################################
    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            stop_on_error($sformatf("Timeout after %0d cycles, %0d rows still expected",
                                    cycles, exp_q.size()));
        end
        if (resetn && pix_valid_i && !pix_hold_o) begin
            void'(send_q.pop_front());
            rows_in++;
            taken = 1'b1;
        end
        if (resetn && coef_valid_o && !coef_hold_i) begin
            assert (exp_q.size() > 0)
                else stop_on_error("Output row arrived with no block pending");
            exp_row  = exp_q.pop_front();
            exp_name = name_q.pop_front();
            assert (coef_col_o == rows_out % NP) else stop_on_error($sformatf(
                "MISMATCH %s coef_col_o expected %0d actual %0d",
                exp_name, rows_out % NP, coef_col_o));
            assert (coef_flat == exp_row) else stop_on_error($sformatf(
                "MISMATCH %s row %0d expected %h actual %h",
                exp_name, coef_col_o, exp_row, coef_flat));
            rows_out++;
        end
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (!resetn)
        coef_valid_o && coef_hold_i |=> coef_valid_o && $stable(coef_flat) && $stable(coef_col_o))
        else stop_on_error("Coefficient row changed while it was held");

    a_quiet_start: assert property (@(posedge clk) disable iff (!resetn)
        rows_in < NP |-> !coef_valid_o)
        else stop_on_error("coef_valid_o rose before a full block was sent");

    // Two banks plus the rows parked in the row stage, transpose output and column stage.
    a_bounded: assert property (@(posedge clk) disable iff (!resetn)
        rows_in - rows_out <= 2 * NP + 3)
        else stop_on_error("More rows accepted than the pipeline can hold");

    initial begin
        int blk [NP][NP];
        int base;
        void'($urandom(32'hd8ece395));
        resetn      = 1'b0;
        pix_valid_i = 1'b0;
        pix_row_i   = '0;
        coef_hold_i = 1'b0;
        taken       = 1'b0;
        rows_in     = 0;
        rows_out    = 0;
        cycles      = 0;
        gap_pct     = 0;
        hold_pct    = 0;
        for (int n = 0; n < NP; n++) begin
            pix_i[n] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        assert (!coef_valid_o) else stop_on_error("coef_valid_o high after reset");
        @(posedge clk);

        for (int kind = 0; kind < 4; kind++) begin
            make_block(kind, blk);
            send_block("corner", blk);
        end
        wait_drain();

        gap_pct  = 25;  // Gaps on the input, random hold on the output.
        hold_pct = 30;
        for (int b = 0; b < N_RAND; b++) begin
            make_block(4, blk);
            send_block("random", blk);
        end
        wait_drain();

        // Back-to-back rows into a fully held output.
        gap_pct  = 0;
        hold_pct = 100;
        base     = rows_in;
        for (int b = 0; b < N_STALL; b++) begin
            make_block(4, blk);
            send_block("stall", blk);
        end
        while (rows_in < base + 2 * NP) begin
            @(posedge clk);
        end
        repeat (2 * NP * NP) @(posedge clk);
        @(negedge clk);
        assert (pix_hold_o && send_q.size() > 0)
            else stop_on_error("Input was not stalled by the held output");
        @(posedge clk);
        hold_pct = 30;
        wait_drain();

        // A stray row in this window has no expected value.
        hold_pct = 0;
        repeat (4 * NP * NP) @(posedge clk);
        @(negedge clk);
        if (!coef_valid_o && !pix_hold_o && rows_in == N_BLK * NP) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_on_error("Pipeline did not return to idle after the last block");
        end
    end

endmodule

/* verilog.f */
+incdir+sim
source/dct_types_pkg.sv
source/dct_ctrl_pkg.sv
source/dp_ram_be.sv
source/dct_1d.sv
source/transpose.sv
source/dct_2d.sv
sim/tb_dct_2d.sv
